// ==== common/noc_pkg.sv ====
/*
 Shared types and sizes for the five-port wormhole mesh router.
 FIFO_DEPTH must be a power of two. A head flit carries the destination
 x in data[7:0] and the destination y in data[15:8].
*/
package noc_pkg;

   localparam int NUM_PORTS  = 5;
   localparam int DATA_W     = 32;
   localparam int COORD_W    = 8;
   localparam int FIFO_DEPTH = 4;

   // Derived sizes for the input FIFO.
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

   // Flit types of a wormhole packet.
   typedef enum logic [1:0] {
      FLIT_HEAD = 2'd0,
      FLIT_BODY = 2'd1,
      FLIT_TAIL = 2'd2
   } flit_kind_e;

   typedef struct packed {
      flit_kind_e        kind;
      logic [DATA_W-1:0] data;
   } flit_t;

   // Port order follows the south, west, north, east, local convention.
   typedef enum logic [2:0] {
      PORT_SOUTH = 3'd0,
      PORT_WEST  = 3'd1,
      PORT_NORTH = 3'd2,
      PORT_EAST  = 3'd3,
      PORT_LOCAL = 3'd4
   } port_e;

   // One bit per port, indexed by port_e.
   typedef logic [NUM_PORTS-1:0] port_vec_t;

   // Output arbiter state.
   typedef enum logic {
      ARB_IDLE   = 1'b0,
      ARB_LOCKED = 1'b1
   } arb_state_e;

endpackage

// ==== router/input_unit.sv ====
/*
 Input port of the router. Small flit FIFO plus XY routing of the head flit.
 Body and tail flits follow the route latched when their head left the FIFO.
 Packets must start with a head flit and end with a tail flit.
*/
`timescale 1ns/1ps

module input_unit
   import noc_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic [COORD_W-1:0] router_x,
   input  logic [COORD_W-1:0] router_y,
   input  flit_t              in_flit,
   input  logic               in_valid,
   output logic               in_ready,
   input  port_vec_t          take,
   output port_vec_t          req,
   output flit_t              head_flit
);

   flit_t              mem [FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               push;
   logic               pop;
   logic               empty;
   logic [COORD_W-1:0] dest_x;
   logic [COORD_W-1:0] dest_y;
   port_e              xy_route;
   port_e              route_reg;
   logic               route_held;

   assign empty     = (count == '0);
   assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
   assign push      = in_valid && in_ready;
   assign pop       = (|take) && !empty;
   assign head_flit = mem[rd_ptr];

   // Flit storage.
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // XY routing resolves x before y.
   assign dest_x = head_flit.data[COORD_W-1:0];
   assign dest_y = head_flit.data[2*COORD_W-1:COORD_W];

   always_comb begin
      if (dest_x > router_x) begin
         xy_route = PORT_EAST;
      end else if (dest_x < router_x) begin
         xy_route = PORT_WEST;
      end else if (dest_y > router_y) begin
         xy_route = PORT_NORTH;
      end else if (dest_y < router_y) begin
         xy_route = PORT_SOUTH;
      end else begin
         xy_route = PORT_LOCAL;
      end
   end

   always_comb begin
      req = '0;
      if (!empty) begin
         if (head_flit.kind == FLIT_HEAD) begin
            req[xy_route] = 1'b1;
         end else if (route_held) begin
            req[route_reg] = 1'b1;
         end
      end
   end

   // Route is held from head pop to tail pop.
   always_ff @(posedge clk) begin
      if (reset) begin
         route_held <= 1'b0;
         route_reg  <= PORT_LOCAL;
      end else if (pop) begin
         if (head_flit.kind == FLIT_HEAD) begin
            route_held <= 1'b1;
            route_reg  <= xy_route;
         end else if (head_flit.kind == FLIT_TAIL) begin
            route_held <= 1'b0;
         end
      end
   end

endmodule

// ==== router/output_unit.sv ====
/*
 Output port of the router. Round-robin arbiter that stays locked to one
 input from head to tail, so packets never interleave on this port.
 A single output register gives one flit per cycle with out_ready high.
*/
`timescale 1ns/1ps

module output_unit
   import noc_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  port_vec_t req,
   input  flit_t     head_flit [NUM_PORTS],
   output port_vec_t take,
   output flit_t     out_flit,
   output logic      out_valid,
   input  logic      out_ready
);

   arb_state_e arb_state;
   port_e      owner;
   port_e      rr_ptr;
   port_e      sel_port;
   port_e      next_ptr;
   logic       sel_found;
   logic       can_load;
   logic       grant;
   flit_t      sel_flit;

   // Only the owner while locked, otherwise the first requester from rr_ptr on.
   always_comb begin
      int idx;
      idx       = 0;
      sel_found = 1'b0;
      sel_port  = PORT_SOUTH;
      if (arb_state == ARB_LOCKED) begin
         sel_port  = owner;
         sel_found = req[owner];
      end else begin
         for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % NUM_PORTS;
            if (req[idx]) begin
               sel_found = 1'b1;
               sel_port  = port_e'(3'(idx));
            end
         end
      end
   end

   assign can_load = !out_valid || out_ready;
   assign grant    = sel_found && can_load;
   assign sel_flit = head_flit[sel_port];
   assign next_ptr = (sel_port == PORT_LOCAL) ? PORT_SOUTH : port_e'(sel_port + 3'd1);

   always_comb begin
      take = '0;
      if (grant) begin
         take[sel_port] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         arb_state <= ARB_IDLE;
         owner     <= PORT_SOUTH;
         rr_ptr    <= PORT_SOUTH;
         out_valid <= 1'b0;
      end else begin
         if (grant) begin
            out_valid <= 1'b1;
            if (sel_flit.kind == FLIT_TAIL) begin
               arb_state <= ARB_IDLE;
            end else begin
               arb_state <= ARB_LOCKED;
            end
            // A new packet moves the pointer past the winner.
            if (arb_state == ARB_IDLE) begin
               owner  <= sel_port;
               rr_ptr <= next_ptr;
            end
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (grant) begin
         out_flit <= sel_flit;
      end
   end

endmodule

// ==== verilog/noc_router.sv ====
/*
 Five-port wormhole mesh router with clocked valid/ready links.
 Per-port arrays are indexed by port_e. Routing is XY against router_x
 and router_y, with east as +x and north as +y.
*/
`timescale 1ns/1ps

module noc_router
   import noc_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic [COORD_W-1:0] router_x,
   input  logic [COORD_W-1:0] router_y,
   input  flit_t              in_flit   [NUM_PORTS],
   input  logic               in_valid  [NUM_PORTS],
   output logic               in_ready  [NUM_PORTS],
   output flit_t              out_flit  [NUM_PORTS],
   output logic               out_valid [NUM_PORTS],
   input  logic               out_ready [NUM_PORTS]
);

   port_vec_t req_from_in   [NUM_PORTS];
   port_vec_t req_to_out    [NUM_PORTS];
   port_vec_t take_from_out [NUM_PORTS];
   port_vec_t take_to_in    [NUM_PORTS];
   flit_t     head_of       [NUM_PORTS];

   // Requests go row to column, takes come back column to row.
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xpose
      for (genvar j = 0; j < NUM_PORTS; j++) begin : g_bit
         assign req_to_out[j][i] = req_from_in[i][j];
         assign take_to_in[i][j] = take_from_out[j][i];
      end
   end

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      input_unit u_in (
         .clk       (clk),
         .reset     (reset),
         .router_x  (router_x),
         .router_y  (router_y),
         .in_flit   (in_flit[p]),
         .in_valid  (in_valid[p]),
         .in_ready  (in_ready[p]),
         .take      (take_to_in[p]),
         .req       (req_from_in[p]),
         .head_flit (head_of[p])
      );

      output_unit u_out (
         .clk       (clk),
         .reset     (reset),
         .req       (req_to_out[p]),
         .head_flit (head_of),
         .take      (take_from_out[p]),
         .out_flit  (out_flit[p]),
         .out_valid (out_valid[p]),
         .out_ready (out_ready[p])
      );
   end

endmodule

// ==== dv/tb_vectors.svh ====
/*
 Packet table for the router testbench, included inside the testbench module.
 The router sits at (3,3). A row with stall set holds the out_ready of the
 packet's output low for a stretch, then toggles it, starting at its launch.
*/
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns are source port, dest x, dest y, body flits, start cycle, stall.
typedef struct packed {
   logic [2:0]  src;
   logic [7:0]  dest_x;
   logic [7:0]  dest_y;
   logic [7:0]  body_len;
   logic [15:0] start_cycle;
   logic        stall;
} pkt_row_t;

localparam int NUM_PKTS = 18;

localparam pkt_row_t PKT_TABLE [NUM_PKTS] = '{
   // One packet per direction, one at a time.
   '{3'd4, 8'd5, 8'd3, 8'd2,  16'd0,   1'b0},
   '{3'd4, 8'd1, 8'd3, 8'd1,  16'd10,  1'b0},
   '{3'd0, 8'd3, 8'd6, 8'd3,  16'd20,  1'b0},
   '{3'd2, 8'd3, 8'd0, 8'd0,  16'd30,  1'b0},
   '{3'd3, 8'd3, 8'd3, 8'd2,  16'd40,  1'b0},
   '{3'd1, 8'd7, 8'd1, 8'd1,  16'd50,  1'b0},
   // Two inputs, then three, into one output.
   '{3'd0, 8'd3, 8'd3, 8'd5,  16'd70,  1'b0},
   '{3'd2, 8'd3, 8'd3, 8'd5,  16'd70,  1'b0},
   '{3'd1, 8'd6, 8'd2, 8'd4,  16'd100, 1'b0},
   '{3'd0, 8'd9, 8'd3, 8'd4,  16'd100, 1'b0},
   '{3'd4, 8'd4, 8'd4, 8'd4,  16'd100, 1'b0},
   '{3'd0, 8'd5, 8'd0, 8'd2,  16'd100, 1'b0},
   // Back-pressure on the north output.
   '{3'd4, 8'd3, 8'd5, 8'd12, 16'd150, 1'b1},
   // Five inputs to five distinct outputs.
   '{3'd0, 8'd0, 8'd3, 8'd3,  16'd240, 1'b0},
   '{3'd1, 8'd8, 8'd3, 8'd3,  16'd240, 1'b0},
   '{3'd2, 8'd3, 8'd3, 8'd3,  16'd240, 1'b0},
   '{3'd3, 8'd3, 8'd1, 8'd3,  16'd240, 1'b0},
   '{3'd4, 8'd3, 8'd9, 8'd3,  16'd240, 1'b0}
};

`endif

// ==== dv/tb_noc_router.sv ====
/*
 Testbench for the five-port router at (3,3). Inputs change 1 ns after the
 rising edge and all link signals are sampled at the falling edge.
 Expected output ports come from the XY rule, with east as +x, north as +y.
*/
`timescale 1ns/1ps

module tb_noc_router
   import noc_pkg::*;
;

   localparam int ROUTER_X = 3;
   localparam int ROUTER_Y = 3;
   localparam int CHK_W    = $bits(flit_t);

   `include "tb_vectors.svh"

   logic               clk;
   logic               reset;
   logic [COORD_W-1:0] router_x;
   logic [COORD_W-1:0] router_y;
   flit_t              in_flit   [NUM_PORTS];
   logic               in_valid  [NUM_PORTS];
   logic               in_ready  [NUM_PORTS];
   flit_t              out_flit  [NUM_PORTS];
   logic               out_valid [NUM_PORTS];
   logic               out_ready [NUM_PORTS];

   flit_t       send_q [NUM_PORTS][$];
   flit_t       exp_q  [NUM_PORTS][NUM_PORTS][$];
   int          owner       [NUM_PORTS];
   int          stall_start [NUM_PORTS];
   logic        saw_full    [NUM_PORTS];
   logic        launched    [NUM_PKTS];
   int          stall_src;
   int          cyc;
   int          errors;
   logic [31:0] rng_state;

   noc_router u_dut (
      .clk       (clk),
      .reset     (reset),
      .router_x  (router_x),
      .router_y  (router_y),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // X first, then y, else local.
   function automatic int route_of(input logic [7:0] dx, input logic [7:0] dy);
      if (int'(dx) > ROUTER_X) return 3;
      if (int'(dx) < ROUTER_X) return 1;
      if (int'(dy) > ROUTER_Y) return 2;
      if (int'(dy) < ROUTER_Y) return 0;
      return 4;
   endfunction

   function automatic int total_flits();
      int n;
      n = 0;
      for (int r = 0; r < NUM_PKTS; r++) begin
         n = n + int'(PKT_TABLE[r].body_len) + 2;
      end
      return n;
   endfunction

   // Low for 40 cycles, toggling for 20, then high again.
   function automatic logic ready_for(input int p, input int c);
      int d;
      d = c - stall_start[p];
      if (d >= 0 && d < 40) return 1'b0;
      if (d >= 40 && d < 60) return (d % 2) == 0;
      return 1'b1;
   endfunction

   task automatic stop_run();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [CHK_W-1:0] got,
                              input logic [CHK_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic launch_packet(input int r);
      pkt_row_t row;
      flit_t    f;
      int       dst;
      int       src;
      row = PKT_TABLE[r];
      src = int'(row.src);
      dst = route_of(row.dest_x, row.dest_y);
      for (int k = 0; k < int'(row.body_len) + 2; k++) begin
         rng_state = xorshift(rng_state);
         if (k == 0) begin
            f.kind = FLIT_HEAD;
            f.data = {rng_state[31:16], row.dest_y, row.dest_x};
         end else begin
            f.kind = (k == int'(row.body_len) + 1) ? FLIT_TAIL : FLIT_BODY;
            f.data = rng_state;
         end
         send_q[src].push_back(f);
         exp_q[dst][src].push_back(f);
      end
      if (row.stall) begin
         stall_start[dst] = cyc;
         stall_src        = src;
         saw_full[src]    = 1'b0;
      end
      launched[r] = 1'b1;
   endtask

   // A head is tied to its source by the random tag in its upper payload bits.
   task automatic take_output(input int p);
      flit_t got;
      int    src;
      got = out_flit[p];
      src = owner[p];
      if (src < 0) begin
         for (int s = 0; s < NUM_PORTS; s++) begin
            if (src < 0 && exp_q[p][s].size() != 0 &&
                exp_q[p][s][0].data[31:16] == got.data[31:16]) begin
               src = s;
            end
         end
      end
      if (src < 0) begin
         $display("Output %0d sent flit %h that starts no expected packet", p, got);
         stop_run();
      end else begin
         check_value($sformatf("out_flit[%0d]", p), got, exp_q[p][src][0]);
         void'(exp_q[p][src].pop_front());
         owner[p] = (got.kind == FLIT_TAIL) ? -1 : src;
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;
      for (int r = 0; r < NUM_PKTS; r++) begin
         if (!launched[r] && int'(PKT_TABLE[r].start_cycle) <= cyc) begin
            launch_packet(r);
         end
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
         in_valid[p] = (send_q[p].size() != 0);
         if (in_valid[p]) begin
            in_flit[p] = send_q[p][0];
         end
         out_ready[p] = ready_for(p, cyc);
      end
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (in_valid[p] && in_ready[p]) begin
            void'(send_q[p].pop_front());
         end else if (in_valid[p]) begin
            saw_full[p] = 1'b1;
         end
         if (out_valid[p] && out_ready[p]) begin
            take_output(p);
         end
      end
      cyc++;
   endtask

   function automatic logic traffic_done();
      for (int r = 0; r < NUM_PKTS; r++) begin
         if (!launched[r]) return 1'b0;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (send_q[p].size() != 0) return 1'b0;
         for (int s = 0; s < NUM_PORTS; s++) begin
            if (exp_q[p][s].size() != 0) return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   initial begin
      int limit;
      limit = total_flits() * 20 + 200;
      repeat (limit + 4) @(posedge clk);
      $display("Timeout: traffic still in flight after %0d cycles", limit);
      stop_run();
   end

   initial begin
      reset     = 1'b1;
      router_x  = COORD_W'(ROUTER_X);
      router_y  = COORD_W'(ROUTER_Y);
      rng_state = 32'd95;
      cyc       = 0;
      errors    = 0;
      stall_src = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         in_flit[p]     = '0;
         in_valid[p]    = 1'b0;
         out_ready[p]   = 1'b1;
         owner[p]       = -1;
         stall_start[p] = -100000;
         saw_full[p]    = 1'b0;
      end
      for (int r = 0; r < NUM_PKTS; r++) begin
         launched[r] = 1'b0;
      end
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
         check_value($sformatf("out_valid[%0d]", p), CHK_W'(out_valid[p]), CHK_W'(1'b0));
         check_value($sformatf("in_ready[%0d]", p), CHK_W'(in_ready[p]), CHK_W'(1'b1));
      end
      while (!traffic_done()) begin
         step_cycle();
      end
      // A quiet stretch at the end lets a duplicated flit show up.
      repeat (20) step_cycle();
      check_value("in_ready low during stall", CHK_W'(saw_full[stall_src]), CHK_W'(1'b1));
      if (errors == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         stop_run();
      end
   end

endmodule

// ==== noc_router.f ====
+incdir+dv
common/noc_pkg.sv
router/input_unit.sv
router/output_unit.sv
verilog/noc_router.sv
dv/tb_noc_router.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the router testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f noc_router.f --top-module tb_noc_router -o sim_noc_router
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_noc_router > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
fi

if grep -q "All checks passed" sim.log; then
   echo "Result: PASS"
   exit 0
else
   echo "Result: FAIL"
   exit 1
fi
